/* exec_stimulus.txt */
# gap(dec) pc instr result branch target reg_write, all but gap in hex
# gap is the number of idle cycles before the instruction
2 00000000 06400093 00000064 0 00000000 1
0 00000004 ff900113 fffffff9 0 00000000 1
0 00000008 7ff00193 000007ff 0 00000000 1
0 0000000c fff00213 ffffffff 0 00000000 1
0 00000010 00500293 00000005 0 00000000 1
5 00000014 00208333 0000005d 0 00000000 1
1 00000018 401103b3 ffffff95 0 00000000 1
0 0000001c 00520433 00000004 0 00000000 1
2 00000020 004144b3 00000006 0 00000000 1
0 00000024 0030e533 000007ff 0 00000000 1
0 00000028 0020f5b3 00000060 0 00000000 1
1 0000002c 0f00c613 00000094 0 00000000 1
0 00000030 0030e693 00000067 0 00000000 1
0 00000034 ff027713 fffffff0 0 00000000 1
1 00000038 005117b3 ffffff20 0 00000000 1
0 0000003c 00515833 07ffffff 0 00000000 1
0 00000040 405158b3 ffffffff 0 00000000 1
0 00000044 40115913 fffffffc 0 00000000 1
3 00000048 001129b3 00000001 0 00000000 1
0 0000004c 00113a33 00000000 0 00000000 1
0 00000050 fff0aa93 00000000 0 00000000 1
0 00000054 fff0bb13 00000001 0 00000000 1
1 00000100 00108863 00000000 1 00000110 0
0 00000120 00208863 00000000 0 00000130 0
0 00000200 fe109ce3 00000000 0 000001f8 0
0 00000220 00209863 00000000 1 00000230 0
2 00000300 00114863 00000000 1 00000310 0
0 00000320 fe20cce3 00000000 0 00000318 0
0 00000310 00115863 00000000 0 00000320 0
0 00000330 fe20dce3 00000000 1 00000328 0
1 00000400 fe116ce3 00000000 0 000003f8 0
0 00000410 0020e863 00000000 1 00000420 0
0 00000500 fe117ce3 00000000 1 000004f8 0
0 00000510 0020f863 00000000 0 00000520 0
2 00000600 00c0ab83 00000070 0 00000000 1
0 00000604 ffc14c03 fffffff5 0 00000000 1
0 00000608 0020a423 0000006c 0 00000000 0
1 0000060c fe118fa3 000007fe 0 00000000 0
0 00001000 12345c97 12346000 0 00000000 1
0 00001004 00001d37 00000000 0 00000000 0

/* filelist.f */
rv_exec_pkg.sv
instr_decode.sv
reg_file.sv
operand_stage.sv
alu.sv
writeback_stage.sv
exec_top.sv
exec_assertions.sv
exec_tb.sv

/* run.sh */
#!/bin/sh
# Build the execute pipeline testbench with Verilator and run it
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f filelist.f --top-module exec_tb \
    -o exec_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/exec_sim > sim.log 2>&1 || echo "Simulator returned an error status"
grep -q "^TEST OK$" sim.log && echo "Simulation passed" || { cat sim.log; exit 1; }

/* exec_tb.sv */
module exec_tb import rv_exec_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    logic            clk;
    logic            nRst;
    logic            instr_valid;
    logic [xlen-1:0] instr;
    logic [xlen-1:0] pc;
    wb_s             wb;

    int              gap_list[$];
    logic [xlen-1:0] pc_list[$];
    logic [xlen-1:0] instr_list[$];
    logic [xlen-1:0] result_list[$];
    logic            branch_list[$];
    logic [xlen-1:0] target_list[$];
    logic            write_list[$];
    int              pending_idx[$];   // Items in flight, oldest first
    int              pending_stamp[$]; // Edge count when each item was driven
    int              seed = 40047;
    int              cycles = 0;
    int              limit = 1000;
    int              mismatches = 0;
    int              failures = 0;
    int              idx;
    int              stamp;

    exec_top dut0 (.clk, .nRst, .instr_valid, .instr, .pc, .wb);

    always #10 clk = ~clk;

    task automatic check(input string name, input logic [xlen-1:0] expected,
                         input logic [xlen-1:0] actual);
        if (actual !== expected) begin
            mismatches++;
            $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic load_stimulus();
        int              fd;
        int              n;
        int              g;
        string           line;
        logic [xlen-1:0] p;
        logic [xlen-1:0] w;
        logic [xlen-1:0] r;
        logic [xlen-1:0] t;
        logic            b;
        logic            wr;
        fd = $fopen("exec_stimulus.txt", "r");
        if (fd == 0) begin
            failures++;
            $display("Could not open the stimulus file exec_stimulus.txt");
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (line.len() < 2 || line[0] == "#") continue; // Blank or comment
            n = $sscanf(line, "%d %h %h %h %h %h %h", g, p, w, r, b, t, wr);
            if (n != 7) begin
                failures++;
                $display("Stimulus line could not be parsed: %s", line);
            end else begin
                gap_list.push_back(g);
                pc_list.push_back(p);
                instr_list.push_back(w);
                result_list.push_back(r);
                branch_list.push_back(b);
                target_list.push_back(t);
                write_list.push_back(wr);
            end
        end
        $fclose(fd);
        if (gap_list.size() == 0) begin
            failures++;
            $display("The stimulus file holds no instructions");
        end
    endtask

    // Random bits on the bus while the strobe is low
    task automatic idle_cycle();
        @(posedge clk);
        instr_valid <= 1'b0;
        instr <= $random(seed);
        pc <= $random(seed);
    endtask

    task automatic issue(input int i);
        @(posedge clk);
        instr_valid <= 1'b1;
        instr <= instr_list[i];
        pc <= pc_list[i];
        pending_idx.push_back(i);
        pending_stamp.push_back(cycles + 1); // Count once this edge completes
    endtask

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("Timeout: the run did not finish within %0d cycles", limit);
            $display("Errors: %0d mismatches, %0d other failures", mismatches, failures + 1);
            $display("TEST FAILED");
            $finish;
        end
    end

    // Outputs are settled by the falling edge
    always @(negedge clk) begin
        if (nRst && wb.valid) begin
            if (pending_idx.size() == 0) begin
                failures++;
                $display("Output strobe on wb with no instruction in flight");
            end else begin
                idx = pending_idx.pop_front();
                stamp = pending_stamp.pop_front();
                check($sformatf("item %0d latency", idx), 4, cycles - stamp);
                check($sformatf("item %0d result", idx), result_list[idx], wb.result);
                check($sformatf("item %0d branch", idx), {31'b0, branch_list[idx]},
                      {31'b0, wb.branch});
                check($sformatf("item %0d target", idx), target_list[idx], wb.target);
                check($sformatf("item %0d reg_write", idx), {31'b0, write_list[idx]},
                      {31'b0, wb.reg_write});
                if (write_list[idx]) begin
                    check($sformatf("item %0d rd", idx), {27'b0, instr_list[idx][11:7]},
                          {27'b0, wb.rd});
                end
            end
        end
    end

    initial begin
        clk = 1'b0;
        nRst = 1'b0;
        instr_valid = 1'b0;
        instr = '0;
        pc = '0;
        load_stimulus();
        limit = 28; // Reset plus drain margin
        foreach (gap_list[i]) limit += gap_list[i] + 1;
        repeat (8) @(posedge clk);
        nRst <= 1'b1;
        foreach (gap_list[i]) begin
            repeat (gap_list[i]) idle_cycle();
            issue(i);
        end
        idle_cycle();
        while (pending_idx.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk); // Catch stray strobes
        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* exec_assertions.sv */
module exec_assertions import rv_exec_pkg::*; (
    input logic clk,
    input logic nRst,
    input logic instr_valid,
    input wb_s  wb
);

    timeunit 1ns;
    timeprecision 100ps;

    // Four registered stages from the input strobe to wb
    a_input_to_output: assert property (@(posedge clk) disable iff (!nRst)
        $past(instr_valid, 4) |-> wb.valid)
        else $error("wb.valid did not follow instr_valid four cycles later");

    a_output_from_input: assert property (@(posedge clk) disable iff (!nRst)
        wb.valid |-> $past(instr_valid, 4))
        else $error("wb.valid rose without an instruction four cycles earlier");

    a_branch_no_write: assert property (@(posedge clk) disable iff (!nRst)
        !(wb.branch && wb.reg_write))
        else $error("wb.branch and wb.reg_write are high together");

endmodule

bind exec_top exec_assertions u_assertions (.clk, .nRst, .instr_valid, .wb);

/* exec_top.sv */
module exec_top import rv_exec_pkg::*; (
    input  logic            clk,
    input  logic            nRst,
    input  logic            instr_valid,
    input  logic [xlen-1:0] instr,
    input  logic [xlen-1:0] pc,
    output wb_s             wb
);

    decode_s         dec;
    operand_s        ops;
    exec_s           ex;
    logic [4:0]      rd_addr1;
    logic [4:0]      rd_addr2;
    logic [xlen-1:0] rd_data1;
    logic [xlen-1:0] rd_data2;
    logic            wr_en;
    logic [4:0]      wr_addr;
    logic [xlen-1:0] wr_data;

    instr_decode u_decode (.clk, .nRst, .instr_valid, .instr, .pc, .dec);

    operand_stage u_operand (.clk, .nRst, .dec, .rd_addr1, .rd_addr2,
                             .rd_data1, .rd_data2, .ops);

    reg_file u_regs (.clk, .nRst, .rd_addr1, .rd_addr2, .rd_data1, .rd_data2,
                     .wr_en, .wr_addr, .wr_data);

    alu u_alu (.clk, .nRst, .ops, .ex);

    writeback_stage u_wb (.clk, .nRst, .ex, .wr_en, .wr_addr, .wr_data, .wb);

endmodule

/* writeback_stage.sv */
module writeback_stage import rv_exec_pkg::*; (
    input  logic            clk,
    input  logic            nRst,
    input  exec_s           ex,
    output logic            wr_en,
    output logic [4:0]      wr_addr,
    output logic [xlen-1:0] wr_data,
    output wb_s             wb
);

    wb_s wb_n;

    // Register write lands on the same edge that loads wb
    assign wr_en   = ex.valid & ex.reg_write;
    assign wr_addr = ex.rd;
    assign wr_data = ex.result;

    always_comb begin
        wb_n.valid     = ex.valid;
        wb_n.rd        = ex.rd;
        wb_n.reg_write = ex.reg_write;
        wb_n.result    = ex.result;
        wb_n.branch    = ex.branch;
        wb_n.target    = ex.pc + ex.imm; // Both zero for non-branch ops
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            wb <= '0;
        end else begin
            wb <= wb_n;
        end
    end

endmodule

/* alu.sv */
module alu import rv_exec_pkg::*; (
    input  logic     clk,
    input  logic     nRst,
    input  operand_s ops,
    output exec_s    ex
);

    logic [xlen-1:0] in1;
    logic [xlen-1:0] in2;
    logic [xlen-1:0] result_n;
    logic            branch_n;
    logic            is_branch; // Op is one of the six branches
    exec_s           ex_n;

    always_comb begin : input_mux
        case (ops.op)
            OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI, OP_SLLI, OP_SRLI,
            OP_SRAI, OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU, OP_SB, OP_SH, OP_SW: begin
                in1 = ops.rs1_val;
                in2 = ops.imm;
            end
            OP_AUIPC: begin
                in1 = ops.pc;
                in2 = ops.imm;
            end
            default: begin
                in1 = ops.rs1_val;
                in2 = ops.rs2_val;
            end
        endcase
    end

    always_comb begin : operation
        result_n = '0;
        branch_n = 1'b0;
        is_branch = 1'b0;
        case (ops.op)
            OP_ADD, OP_ADDI, OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
            OP_SB, OP_SH, OP_SW, OP_AUIPC: result_n = in1 + in2;
            OP_SUB:             result_n = in1 - in2;
            OP_SLL, OP_SLLI:    result_n = in1 << in2[4:0];
            OP_SLT, OP_SLTI:    result_n = {31'b0, $signed(in1) < $signed(in2)};
            OP_SLTU, OP_SLTIU:  result_n = {31'b0, in1 < in2};
            OP_XOR, OP_XORI:    result_n = in1 ^ in2;
            OP_SRL, OP_SRLI:    result_n = in1 >> in2[4:0];
            OP_SRA, OP_SRAI:    result_n = $unsigned($signed(in1) >>> in2[4:0]); // Sign fill
            OP_OR, OP_ORI:      result_n = in1 | in2;
            OP_AND, OP_ANDI:    result_n = in1 & in2;
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU: begin
                is_branch = 1'b1;
                case (ops.op)
                    OP_BEQ:  branch_n = (in1 == in2);
                    OP_BNE:  branch_n = (in1 != in2);
                    OP_BLT:  branch_n = ($signed(in1) < $signed(in2));
                    OP_BGE:  branch_n = ($signed(in1) >= $signed(in2));
                    OP_BLTU: branch_n = (in1 < in2);
                    default: branch_n = (in1 >= in2); // BGEU
                endcase
            end
            default: result_n = '0; // OP_INVALID
        endcase
    end

    always_comb begin
        ex_n.valid     = ops.valid;
        ex_n.rd        = ops.rd;
        ex_n.reg_write = ops.reg_write;
        ex_n.result    = result_n;
        ex_n.branch    = branch_n;
        // Target operands only for branches, so other ops get a zero target
        ex_n.pc        = is_branch ? ops.pc : '0;
        ex_n.imm       = is_branch ? ops.imm : '0;
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            ex <= '0;
        end else begin
            ex <= ex_n;
        end
    end

endmodule

/* operand_stage.sv */
module operand_stage import rv_exec_pkg::*; (
    input  logic            clk,
    input  logic            nRst,
    input  decode_s         dec,
    output logic [4:0]      rd_addr1,
    output logic [4:0]      rd_addr2,
    input  logic [xlen-1:0] rd_data1,
    input  logic [xlen-1:0] rd_data2,
    output operand_s        ops
);

    operand_s ops_n;

    assign rd_addr1 = dec.rs1; // Register file lookup
    assign rd_addr2 = dec.rs2;

    always_comb begin
        ops_n.valid     = dec.valid;
        ops_n.op        = dec.op;
        ops_n.rd        = dec.rd;
        ops_n.reg_write = dec.reg_write;
        ops_n.rs1_val   = rd_data1;
        ops_n.rs2_val   = rd_data2;
        ops_n.imm       = dec.imm;
        ops_n.pc        = dec.pc;
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            ops <= '0;
        end else begin
            ops <= ops_n;
        end
    end

endmodule

/* reg_file.sv */
module reg_file import rv_exec_pkg::*; (
    input  logic            clk,
    input  logic            nRst,
    input  logic [4:0]      rd_addr1,
    input  logic [4:0]      rd_addr2,
    output logic [xlen-1:0] rd_data1,
    output logic [xlen-1:0] rd_data2,
    input  logic            wr_en,
    input  logic [4:0]      wr_addr,
    input  logic [xlen-1:0] wr_data
);

    logic [xlen-1:0] regs [0:31];

    // Asynchronous reads where x0 stays zero
    assign rd_data1 = regs[rd_addr1];
    assign rd_data2 = regs[rd_addr2];

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && (wr_addr != 5'd0)) begin
            regs[wr_addr] <= wr_data; // Writes to x0 dropped
        end
    end

endmodule

/* instr_decode.sv */
module instr_decode import rv_exec_pkg::*; (
    input  logic            clk,
    input  logic            nRst,
    input  logic            instr_valid,
    input  logic [xlen-1:0] instr,
    input  logic [xlen-1:0] pc,
    output decode_s         dec
);

    typedef enum logic [6:0] {
        MAJ_OP     = 7'b0110011,
        MAJ_OP_IMM = 7'b0010011,
        MAJ_LOAD   = 7'b0000011,
        MAJ_STORE  = 7'b0100011,
        MAJ_BRANCH = 7'b1100011,
        MAJ_AUIPC  = 7'b0010111
    } major_op_t;

    logic [2:0]      funct3;
    logic [6:0]      funct7;
    alu_op_t         op_n;
    imm_fmt_t        fmt;
    logic [xlen-1:0] imm_n;
    logic            writes_rd; // Format has a destination
    decode_s         dec_n;

    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    always_comb begin
        op_n = OP_INVALID;
        fmt = IMM_NONE;
        writes_rd = 1'b0;
        case (major_op_t'(instr[6:0]))
            MAJ_OP: begin
                writes_rd = 1'b1;
                case ({funct7, funct3})
                    {7'h00, 3'd0}: op_n = OP_ADD;
                    {7'h20, 3'd0}: op_n = OP_SUB;
                    {7'h00, 3'd1}: op_n = OP_SLL;
                    {7'h00, 3'd2}: op_n = OP_SLT;
                    {7'h00, 3'd3}: op_n = OP_SLTU;
                    {7'h00, 3'd4}: op_n = OP_XOR;
                    {7'h00, 3'd5}: op_n = OP_SRL;
                    {7'h20, 3'd5}: op_n = OP_SRA;
                    {7'h00, 3'd6}: op_n = OP_OR;
                    {7'h00, 3'd7}: op_n = OP_AND;
                    default:       op_n = OP_INVALID;
                endcase
            end
            MAJ_OP_IMM: begin
                writes_rd = 1'b1;
                fmt = IMM_I;
                case (funct3)
                    3'd0: op_n = OP_ADDI;
                    3'd1: op_n = (funct7 == 7'h00) ? OP_SLLI : OP_INVALID;
                    3'd2: op_n = OP_SLTI;
                    3'd3: op_n = OP_SLTIU;
                    3'd4: op_n = OP_XORI;
                    3'd5: op_n = (funct7 == 7'h00) ? OP_SRLI :
                                 (funct7 == 7'h20) ? OP_SRAI : OP_INVALID;
                    3'd6: op_n = OP_ORI;
                    3'd7: op_n = OP_ANDI;
                endcase
            end
            MAJ_LOAD: begin
                writes_rd = 1'b1;
                fmt = IMM_I;
                case (funct3)
                    3'd0:    op_n = OP_LB;
                    3'd1:    op_n = OP_LH;
                    3'd2:    op_n = OP_LW;
                    3'd4:    op_n = OP_LBU;
                    3'd5:    op_n = OP_LHU;
                    default: op_n = OP_INVALID;
                endcase
            end
            MAJ_STORE: begin
                fmt = IMM_S;
                case (funct3)
                    3'd0:    op_n = OP_SB;
                    3'd1:    op_n = OP_SH;
                    3'd2:    op_n = OP_SW;
                    default: op_n = OP_INVALID;
                endcase
            end
            MAJ_BRANCH: begin
                fmt = IMM_B;
                case (funct3)
                    3'd0:    op_n = OP_BEQ;
                    3'd1:    op_n = OP_BNE;
                    3'd4:    op_n = OP_BLT;
                    3'd5:    op_n = OP_BGE;
                    3'd6:    op_n = OP_BLTU;
                    3'd7:    op_n = OP_BGEU;
                    default: op_n = OP_INVALID;
                endcase
            end
            MAJ_AUIPC: begin
                writes_rd = 1'b1;
                fmt = IMM_U;
                op_n = OP_AUIPC;
            end
            default: op_n = OP_INVALID; // LUI, JAL, JALR, FENCE, system
        endcase
    end

    always_comb begin
        case (fmt)
            IMM_I:   imm_n = {{20{instr[31]}}, instr[31:20]};
            IMM_S:   imm_n = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            IMM_B:   imm_n = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                              instr[11:8], 1'b0};
            IMM_U:   imm_n = {instr[31:12], 12'b0};
            default: imm_n = '0;
        endcase
    end

    always_comb begin
        dec_n.valid     = instr_valid;
        dec_n.op        = op_n;
        dec_n.rs1       = instr[19:15];
        dec_n.rs2       = instr[24:20];
        dec_n.rd        = instr[11:7];
        dec_n.reg_write = instr_valid && writes_rd && (op_n != OP_INVALID)
                          && (instr[11:7] != 5'd0);
        dec_n.imm       = imm_n;
        dec_n.pc        = pc;
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            dec <= '0;
        end else begin
            dec <= dec_n;
        end
    end

endmodule

/* rv_exec_pkg.sv */
package rv_exec_pkg;

    localparam int xlen = 32; // Data path width

    typedef enum logic [5:0] {
        OP_INVALID = 6'd0,  // Unsupported encoding
        OP_ADD     = 6'd1,  // R type
        OP_SUB     = 6'd2,
        OP_SLL     = 6'd3,
        OP_SLT     = 6'd4,
        OP_SLTU    = 6'd5,
        OP_XOR     = 6'd6,
        OP_SRL     = 6'd7,
        OP_SRA     = 6'd8,
        OP_OR      = 6'd9,
        OP_AND     = 6'd10,
        OP_ADDI    = 6'd11, // I type
        OP_SLTI    = 6'd12,
        OP_SLTIU   = 6'd13,
        OP_XORI    = 6'd14,
        OP_ORI     = 6'd15,
        OP_ANDI    = 6'd16,
        OP_SLLI    = 6'd17,
        OP_SRLI    = 6'd18,
        OP_SRAI    = 6'd19,
        OP_LB      = 6'd20, // Loads compute only an address
        OP_LH      = 6'd21,
        OP_LW      = 6'd22,
        OP_LBU     = 6'd23,
        OP_LHU     = 6'd24,
        OP_SB      = 6'd25, // Stores compute only an address
        OP_SH      = 6'd26,
        OP_SW      = 6'd27,
        OP_BEQ     = 6'd28, // B type
        OP_BNE     = 6'd29,
        OP_BLT     = 6'd30,
        OP_BGE     = 6'd31,
        OP_BLTU    = 6'd32,
        OP_BGEU    = 6'd33,
        OP_AUIPC   = 6'd35  // U type
    } alu_op_t;

    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_S,
        IMM_B,
        IMM_U
    } imm_fmt_t;

    typedef struct packed {
        logic            valid;
        alu_op_t         op;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        logic            reg_write;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] pc;
    } decode_s;

    typedef struct packed {
        logic            valid;
        alu_op_t         op;
        logic [4:0]      rd;
        logic            reg_write;
        logic [xlen-1:0] rs1_val;
        logic [xlen-1:0] rs2_val;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] pc;
    } operand_s;

    typedef struct packed {
        logic            valid;
        logic [4:0]      rd;
        logic            reg_write;
        logic [xlen-1:0] result;
        logic            branch;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] imm;     // Zero unless a branch
    } exec_s;

    typedef struct packed {
        logic            valid;
        logic [4:0]      rd;
        logic            reg_write;
        logic [xlen-1:0] result;
        logic            branch;
        logic [xlen-1:0] target;
    } wb_s;

endpackage
